// File: src.f
src/ahb_pkg.sv
src/bridge_pkg.sv
src/cmd_queue.sv
src/ahb_addr_phase.sv
src/ahb_data_phase.sv
src/ahb_bridge_top.sv
dv/ahb_slave_model.sv
dv/tb_ahb_bridge.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_ahb_bridge
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Done: errors found" $(LOG); then exit 1; fi
	@grep -q "Done: no errors" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/tb_ahb_bridge.sv
`timescale 1ns/1ps

module tb_ahb_bridge import ahb_pkg::*, bridge_pkg::*; ();

    localparam int N_CMDS = 30;

    logic               hclk;
    logic               hresetn;
    logic               cmd_valid;
    cmd_t               cmd;
    logic               cpl_valid;
    cpl_t               cpl;
    logic [HADDR_W-1:0] haddr;
    htrans_e            htrans;
    logic               hwrite;
    hsize_t             hsize;
    hburst_t            hburst;
    logic [HDATA_W-1:0] hwdata;
    logic [HDATA_W-1:0] hrdata;
    logic               hbusreq;
    logic               hready;
    hresp_e             hresp;
    logic               hgrant;

    logic [HDATA_W-1:0] shadow [16];
    cpl_t               exp_q [$];
    cmd_t               addr_q [$];
    int                 n_sent = 0;
    int                 n_done = 0;
    int                 n_err = 0;
    int                 n_tests = 0;
    logic               grant_held = 1'b0;
    logic [ID_W-1:0]    next_id = '0;
    integer             seed = 32'hb9b3;

    ahb_bridge_top i_ahb_bridge_top (.*);

    ahb_slave_model i_slave (.*);

    initial begin
        hclk = 1'b0;
        forever #20 hclk = ~hclk;
    end

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////
    function automatic cpl_t expected_cpl(input cmd_t c);
        cpl_t       e;
        logic [3:0] idx;
        idx     = c.addr[6:3];
        e.write = c.write;
        e.id    = c.id;
        e.resp  = c.addr[31] ? ERROR : OKAY;
        e.rdata = shadow[idx];
        // error region never stores
        if (c.write && !c.addr[31]) begin
            shadow[idx] = c.wdata;
        end
        return e;
    endfunction

    function automatic logic [HADDR_W-1:0] addr_of(input logic err, input logic [3:0] idx);
        return {err, 24'h0, idx, 3'b000};
    endfunction

    // called 2 ns after a rising edge, returns at the same point
    task automatic send_cmd(input logic write, input logic [HADDR_W-1:0] addr,
                            input logic [HDATA_W-1:0] wdata);
        cmd_t c;
        while (n_sent - n_done >= CMD_DEPTH) begin
            @(posedge hclk);
            #2;
        end
        c.write = write;
        c.id    = next_id;
        // cycle through every size the 64-bit bus allows
        c.size  = 3'(next_id[1:0]);
        c.addr  = addr;
        c.wdata = wdata;
        exp_q.push_back(expected_cpl(c));
        addr_q.push_back(c);
        cmd       = c;
        cmd_valid = 1'b1;
        @(posedge hclk);
        #2;
        cmd_valid = 1'b0;
        n_sent++;
        next_id++;
    endtask

    task automatic wait_drain();
        while (n_done != n_sent) begin
            @(posedge hclk);
            #2;
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        n_tests++;
        if (n_err == err_before) begin
            $display("test %0d %s: passed", n_tests, name);
        end else begin
            $display("test %0d %s: failed with %0d errors", n_tests, name, n_err - err_before);
        end
    endtask

    ////////////////////////////////////////
    // comparer
    ////////////////////////////////////////
    always @(negedge hclk) begin
        cpl_t e;
        if (hresetn && cpl_valid) begin
            if (exp_q.size() == 0) begin
                $display("ERROR at %0t: completion id %0d with no command outstanding",
                         $time, cpl.id);
                n_err++;
            end else begin
                e = exp_q.pop_front();
                if (cpl.id !== e.id) begin
                    $display("ERROR at %0t: id got %0d exp %0d", $time, cpl.id, e.id);
                    n_err++;
                end
                if (cpl.write !== e.write) begin
                    $display("ERROR at %0t: id %0d write flag wrong", $time, e.id);
                    n_err++;
                end
                if (cpl.resp !== e.resp) begin
                    $display("ERROR at %0t: id %0d resp got %0d exp %0d",
                             $time, e.id, cpl.resp, e.resp);
                    n_err++;
                end
                if (!e.write && cpl.rdata !== e.rdata) begin
                    $display("ERROR at %0t: id %0d rdata got %h exp %h",
                             $time, e.id, cpl.rdata, e.rdata);
                    n_err++;
                end
            end
            n_done++;
        end
    end

    // each accepted address phase carries the next command in order
    always @(negedge hclk) begin
        cmd_t a;
        if (hresetn && htrans == NONSEQ && hready) begin
            if (addr_q.size() == 0) begin
                $display("ERROR at %0t: address phase with no command outstanding", $time);
                n_err++;
            end else begin
                a = addr_q.pop_front();
                if (haddr !== a.addr || hwrite !== a.write) begin
                    $display("ERROR at %0t: id %0d haddr %h hwrite %0b exp %h %0b",
                             $time, a.id, haddr, hwrite, a.addr, a.write);
                    n_err++;
                end
                if (hsize !== a.size || hburst !== HBURST_SINGLE) begin
                    $display("ERROR at %0t: id %0d hsize %0d hburst %0d exp %0d %0d",
                             $time, a.id, hsize, hburst, a.size, HBURST_SINGLE);
                    n_err++;
                end
            end
        end
    end

    // no transfer may start while the arbiter withholds the bus
    always @(negedge hclk) begin
        if (grant_held && htrans == NONSEQ) begin
            $display("ERROR at %0t: NONSEQ driven without hgrant", $time);
            n_err++;
        end
    end

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////
    initial begin
        int          err0;
        logic [31:0] rnd;
        hresetn   = 1'b0;
        cmd_valid = 1'b0;
        cmd       = '0;
        hgrant    = 1'b1;
        for (int i = 0; i < 16; i++) begin
            shadow[i] = 64'h0f1e_2d3c_4b5a_6978 ^ {16{4'(i)}};
        end
        repeat (2) @(posedge hclk);
        #2;
        hresetn = 1'b1;

        err0 = n_err;
        @(negedge hclk);
        if (htrans != IDLE || hbusreq || cpl_valid) begin
            $display("ERROR at %0t: bus or completion active after reset", $time);
            n_err++;
        end
        @(posedge hclk);
        #2;
        end_test("reset state", err0);

        err0 = n_err;
        for (int i = 0; i < 4; i++) begin
            send_cmd(1'b1, addr_of(1'b0, 4'(3 * i + 1)), {32'hcafe_0000 + 32'(i), 32'(~i)});
        end
        for (int i = 0; i < 4; i++) begin
            send_cmd(1'b0, addr_of(1'b0, 4'(3 * i + 1)), '0);
        end
        wait_drain();
        end_test("write then read", err0);

        err0 = n_err;
        repeat (4) begin
            wait_drain();
            for (int i = 0; i < CMD_DEPTH; i++) begin
                rnd = $random(seed);
                send_cmd(rnd[0], addr_of(1'b0, rnd[4:1]), {$random(seed), $random(seed)});
            end
        end
        wait_drain();
        end_test("back-to-back bursts", err0);

        err0 = n_err;
        send_cmd(1'b1, addr_of(1'b1, 4'd4), 64'hdead_beef_dead_beef);
        send_cmd(1'b0, addr_of(1'b1, 4'd7), '0);
        send_cmd(1'b0, addr_of(1'b0, 4'd4), '0);
        wait_drain();
        end_test("error region", err0);

        err0 = n_err;
        hgrant     = 1'b0;
        grant_held = 1'b1;
        for (int i = 0; i < 3; i++) begin
            send_cmd(i[0], addr_of(1'b0, 4'(i + 12)), 64'h5a5a_0000_0000_0000 + 64'(i));
        end
        repeat (8) @(posedge hclk);
        #2;
        if (!hbusreq) begin
            $display("ERROR at %0t: hbusreq low with commands queued", $time);
            n_err++;
        end
        grant_held = 1'b0;
        hgrant     = 1'b1;
        wait_drain();
        end_test("grant withheld", err0);

        if (exp_q.size() != 0) begin
            $display("%0d expected completions never arrived", exp_q.size());
            n_err++;
        end
        $display("tests: %0d  commands: %0d  completions: %0d  errors: %0d",
                 n_tests, n_sent, n_done, n_err);
        if (n_err == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        repeat (N_CMDS * 30) @(posedge hclk);
        $display("timeout: run did not finish within %0d clock cycles", N_CMDS * 30);
        $display("Done: errors found");
        $finish;
    end

endmodule

// File: dv/ahb_slave_model.sv
`timescale 1ns/1ps

module ahb_slave_model import ahb_pkg::*; (
    input  logic               hclk,
    input  logic               hresetn,
    input  logic [HADDR_W-1:0] haddr,
    input  htrans_e            htrans,
    input  logic               hwrite,
    input  logic [HDATA_W-1:0] hwdata,
    output logic               hready,
    output logic [HDATA_W-1:0] hrdata,
    output hresp_e             hresp
);

    logic [HDATA_W-1:0] mem [16];
    logic               dp_valid;
    logic               dp_write;
    logic               dp_err;
    logic [3:0]         dp_idx;
    logic [1:0]         wait_cnt;
    logic [1:0]         n_wait;
    integer             seed = 32'hb9b3;

    always @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            for (int i = 0; i < 16; i++) begin
                mem[i] = 64'h0f1e_2d3c_4b5a_6978 ^ {16{4'(i)}};
            end
            dp_valid <= 1'b0;
            dp_write <= 1'b0;
            dp_err   <= 1'b0;
            dp_idx   <= '0;
            wait_cnt <= '0;
            hready   <= 1'b1;
            hresp    <= OKAY;
            hrdata   <= '0;
        end else if (hready) begin
            // previous data phase ends here, store first so a read right behind sees it
            if (dp_valid && dp_write && !dp_err) begin
                mem[dp_idx] = hwdata;
            end
            hresp    <= OKAY;
            dp_valid <= (htrans == NONSEQ);
            if (htrans == NONSEQ) begin
                n_wait = 2'({$random(seed)} % 3);
                dp_write <= hwrite;
                dp_idx   <= haddr[6:3];
                dp_err   <= haddr[31];
                if (haddr[31]) begin
                    // first cycle of the two-cycle ERROR
                    hready <= 1'b0;
                    hresp  <= ERROR;
                end else if (n_wait != 2'd0) begin
                    hready   <= 1'b0;
                    wait_cnt <= n_wait - 2'd1;
                end else begin
                    hready <= 1'b1;
                    hrdata <= mem[haddr[6:3]];
                end
            end
        end else begin
            // hresp holds ERROR into the second cycle
            if (dp_err || wait_cnt == 2'd0) begin
                hready <= 1'b1;
                hrdata <= mem[dp_idx];
            end else begin
                wait_cnt <= wait_cnt - 2'd1;
            end
        end
    end

endmodule

// File: src/ahb_bridge_top.sv
`timescale 1ns/1ps

module ahb_bridge_top import ahb_pkg::*, bridge_pkg::*; (
    input  logic               hclk,
    input  logic               hresetn,
    input  logic               cmd_valid,
    input  cmd_t               cmd,
    output logic               cpl_valid,
    output cpl_t               cpl,
    output logic [HADDR_W-1:0] haddr,
    output htrans_e            htrans,
    output logic               hwrite,
    output hsize_t             hsize,
    output hburst_t            hburst,
    output logic [HDATA_W-1:0] hwdata,
    output logic               hbusreq,
    input  logic               hready,
    input  logic [HDATA_W-1:0] hrdata,
    input  hresp_e             hresp,
    input  logic               hgrant
);

    cmd_t     head;
    logic     empty;
    logic     pop;
    ahb_req_t ahb_req;
    cmd_t     addr_cmd;

    cmd_queue #(
        .DEPTH(CMD_DEPTH)
    ) i_cmd_queue (
        .hclk     (hclk),
        .hresetn  (hresetn),
        .push     (cmd_valid),
        .push_cmd (cmd),
        .pop      (pop),
        .head     (head),
        .empty    (empty)
    );

    ahb_addr_phase i_ahb_addr_phase (
        .hclk     (hclk),
        .hresetn  (hresetn),
        .head     (head),
        .empty    (empty),
        .hgrant   (hgrant),
        .hready   (hready),
        .pop      (pop),
        .hbusreq  (hbusreq),
        .ahb_req  (ahb_req),
        .addr_cmd (addr_cmd)
    );

    ahb_data_phase i_ahb_data_phase (
        .hclk      (hclk),
        .hresetn   (hresetn),
        .ahb_req   (ahb_req),
        .addr_cmd  (addr_cmd),
        .hready    (hready),
        .hrdata    (hrdata),
        .hresp     (hresp),
        .hwdata    (hwdata),
        .cpl_valid (cpl_valid),
        .cpl       (cpl)
    );

    // address-phase pins
    assign haddr  = ahb_req.haddr;
    assign htrans = ahb_req.htrans;
    assign hwrite = ahb_req.hwrite;
    assign hsize  = ahb_req.hsize;
    assign hburst = ahb_req.hburst;

endmodule

// File: src/ahb_data_phase.sv
`timescale 1ns/1ps

module ahb_data_phase import ahb_pkg::*, bridge_pkg::*; (
    input  logic               hclk,
    input  logic               hresetn,
    input  ahb_req_t           ahb_req,
    input  cmd_t               addr_cmd,
    input  logic               hready,
    input  logic [HDATA_W-1:0] hrdata,
    input  hresp_e             hresp,
    output logic [HDATA_W-1:0] hwdata,
    output logic               cpl_valid,
    output cpl_t               cpl
);

    logic            accept;
    logic            dp_valid;
    logic            dp_write;
    logic [ID_W-1:0] dp_id;

    assign accept = (ahb_req.htrans == NONSEQ) && hready;

    ////////////////////////////////////////
    // data phase tracking
    ////////////////////////////////////////
    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            dp_valid <= 1'b0;
        end else if (hready) begin
            dp_valid <= accept;
        end
    end

    // write data and tags follow the accepted address phase
    always_ff @(posedge hclk) begin
        if (accept) begin
            dp_write <= addr_cmd.write;
            dp_id    <= addr_cmd.id;
            hwdata   <= addr_cmd.wdata;
        end
    end

    ////////////////////////////////////////
    // completion
    ////////////////////////////////////////
    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            cpl_valid <= 1'b0;
        end else begin
            cpl_valid <= dp_valid && hready;
        end
    end

    always_ff @(posedge hclk) begin
        if (dp_valid && hready) begin
            cpl.write <= dp_write;
            cpl.id    <= dp_id;
            cpl.resp  <= hresp;
            cpl.rdata <= hrdata;
        end
    end

    // ERROR is a two-cycle response from the slave
    a_err_two_cycle: assert property (@(posedge hclk) disable iff (!hresetn)
        dp_valid && hready && hresp == ERROR |-> $past(!hready && hresp == ERROR))
        else $error("ahb_data_phase: ERROR without its first wait cycle");

endmodule

// File: src/ahb_addr_phase.sv
`timescale 1ns/1ps

module ahb_addr_phase import ahb_pkg::*, bridge_pkg::*; (
    input  logic     hclk,
    input  logic     hresetn,
    input  cmd_t     head,
    input  logic     empty,
    input  logic     hgrant,
    input  logic     hready,
    output logic     pop,
    output logic     hbusreq,
    output ahb_req_t ahb_req,
    output cmd_t     addr_cmd
);

    // single NONSEQ transfer built from a queued command
    function automatic ahb_req_t nonseq_req(input cmd_t c);
        ahb_req_t r;
        r.haddr  = c.addr;
        r.htrans = NONSEQ;
        r.hwrite = c.write;
        r.hsize  = c.size;
        r.hburst = HBURST_SINGLE;
        return r;
    endfunction

    ////////////////////////////////////////
    // bus request
    ////////////////////////////////////////

    // request while anything waits in the queue
    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            hbusreq <= 1'b0;
        end else begin
            hbusreq <= !empty;
        end
    end

    ////////////////////////////////////////
    // address phase
    ////////////////////////////////////////

    // issue only once we asked for the bus and it was granted
    // hready high means the current address phase is being taken
    assign pop = hready && hgrant && hbusreq && !empty;

    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            ahb_req <= AHB_REQ_IDLE;
        end else if (hready) begin
            if (pop) begin
                ahb_req <= nonseq_req(head);
            end else begin
                ahb_req <= AHB_REQ_IDLE;
            end
        end
    end

    // full command rides along for the data phase
    always_ff @(posedge hclk) begin
        if (pop) begin
            addr_cmd <= head;
        end
    end

    // data phase tags its completion from addr_cmd, wait states included
    a_addr_cmd_match: assert property (@(posedge hclk) disable iff (!hresetn)
        ahb_req.htrans == NONSEQ |-> ahb_req.haddr == addr_cmd.addr
            && ahb_req.hwrite == addr_cmd.write && ahb_req.hsize == addr_cmd.size)
        else $error("ahb_addr_phase: address phase disagrees with its command");

endmodule

// File: src/cmd_queue.sv
`timescale 1ns/1ps

module cmd_queue import bridge_pkg::*; #(
    parameter int DEPTH = CMD_DEPTH
) (
    input  logic hclk,
    input  logic hresetn,
    input  logic push,
    input  cmd_t push_cmd,
    input  logic pop,
    output cmd_t head,
    output logic empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    cmd_t             mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;

    // wrap at DEPTH
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty = (count == '0);
    assign full  = (count == CNT_W'(DEPTH));
    assign head  = mem[rd_ptr];

    // storage
    always_ff @(posedge hclk) begin
        if (push) begin
            mem[wr_ptr] <= push_cmd;
        end
    end

    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // host has no back-pressure so it must keep within DEPTH outstanding
    a_push_full: assert property (@(posedge hclk) disable iff (!hresetn)
        push && full |-> pop)
        else $error("cmd_queue: push while full");

    a_pop_empty: assert property (@(posedge hclk) disable iff (!hresetn)
        pop |-> !empty)
        else $error("cmd_queue: pop while empty");

endmodule

// File: src/bridge_pkg.sv
package bridge_pkg;

    import ahb_pkg::*;

    ////////////////////////////////////////
    // host side sizing
    ////////////////////////////////////////
    localparam int ID_W      = 8;
    localparam int CMD_DEPTH = 4;

    // one host transfer request
    typedef struct packed {
        logic               write;
        logic [ID_W-1:0]    id;
        hsize_t             size;
        logic [HADDR_W-1:0] addr;
        logic [HDATA_W-1:0] wdata;
    } cmd_t;

    // completion returned to the host
    // rdata is only meaningful for reads
    typedef struct packed {
        logic               write;
        logic [ID_W-1:0]    id;
        hresp_e             resp;
        logic [HDATA_W-1:0] rdata;
    } cpl_t;

endpackage

// File: src/ahb_pkg.sv
package ahb_pkg;

    ////////////////////////////////////////
    // bus widths
    ////////////////////////////////////////
    localparam int HADDR_W = 32;
    localparam int HDATA_W = 64;

    ////////////////////////////////////////
    // pin encodings
    ////////////////////////////////////////
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        NONSEQ = 2'b10
    } htrans_e;

    typedef enum logic [1:0] {
        OKAY  = 2'b00,
        ERROR = 2'b01
    } hresp_e;

    typedef logic [2:0] hsize_t;
    typedef logic [2:0] hburst_t;

    localparam hburst_t HBURST_SINGLE = 3'b000;

    // address-phase pins as one word
    typedef struct packed {
        logic [HADDR_W-1:0] haddr;
        htrans_e            htrans;
        logic               hwrite;
        hsize_t             hsize;
        hburst_t            hburst;
    } ahb_req_t;

    // bus parked with no transfer
    localparam ahb_req_t AHB_REQ_IDLE = '{
        haddr:  '0,
        htrans: IDLE,
        hwrite: 1'b0,
        hsize:  '0,
        hburst: HBURST_SINGLE
    };

endpackage
